/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := tb_l1_dcache
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/l1_data_store.sv */
`timescale 1ns/10ps
`include "l1_defines.svh"

module l1_data_store import l1_pkg::*; (
    input  logic                     clk,
    input  logic [`L1_INDEX_WID-1:0] proc_index,
    input  logic                     proc_we,
    input  logic [`L1_DATA_WID-1:0]  proc_wdata,
    input  logic [`L1_INDEX_WID-1:0] snoop_index,
    output logic [`L1_DATA_WID-1:0]  proc_rdata,
    output logic [`L1_DATA_WID-1:0]  snoop_rdata
);

    logic [`L1_DATA_WID-1:0] data_mem [`L1_LINES];

    // processor port, read before write
    always_ff @(posedge clk) begin
        if (proc_we) begin
            data_mem[proc_index] <= proc_wdata;
        end
        proc_rdata <= data_mem[proc_index];
    end

    // snoop read port
    always_ff @(posedge clk) begin
        snoop_rdata <= data_mem[snoop_index];
    end

endmodule

/* design/l1_dcache_top.sv */
`timescale 1ns/10ps
`include "l1_defines.svh"

module l1_dcache_top import l1_pkg::*; (
    input  logic                    clk,
    input  logic                    arst_n,
    // processor
    input  logic                    cpu_req,
    input  cpu_op_e                 cpu_op,
    input  logic [`L1_ADDR_WID-1:0] cpu_addr,
    input  logic [`L1_DATA_WID-1:0] cpu_wdata,
    output logic                    cpu_done,
    output logic [`L1_DATA_WID-1:0] cpu_rdata,
    // level 2
    output logic                    bus_req,
    output bus_op_e                 bus_op,
    output logic [`L1_ADDR_WID-1:0] bus_addr,
    output logic [`L1_DATA_WID-1:0] bus_wdata,
    input  logic                    bus_ack,
    input  logic [`L1_DATA_WID-1:0] bus_rdata,
    input  logic                    bus_shared,
    // snoop
    input  logic                    snoop_req,
    input  snoop_op_e               snoop_op,
    input  logic [`L1_ADDR_WID-1:0] snoop_addr,
    output logic                    snoop_resp,
    output logic                    snoop_hit,
    output logic                    snoop_dirty,
    output logic [`L1_DATA_WID-1:0] snoop_data
);

    // ============================================================
    // internal wiring
    // ============================================================
    logic [`L1_INDEX_WID-1:0] p_tag_index;
    logic                     p_tag_we;
    logic [`L1_TAG_WID-1:0]   p_wtag;
    mesi_e                    p_wstate;
    logic [`L1_TAG_WID-1:0]   p_tag;
    mesi_e                    p_state;
    logic [`L1_INDEX_WID-1:0] p_data_index;
    logic                     p_data_we;
    logic [`L1_DATA_WID-1:0]  p_wdata;
    logic [`L1_DATA_WID-1:0]  p_rdata;

    logic [`L1_INDEX_WID-1:0] s_index;
    logic                     s_we;
    mesi_e                    s_wstate;
    logic [`L1_TAG_WID-1:0]   s_tag;
    mesi_e                    s_state;
    logic [`L1_DATA_WID-1:0]  s_rdata;

    l1_tag_store u_tag_store (
        .clk          (clk),
        .arst_n       (arst_n),
        .proc_index   (p_tag_index),
        .proc_we      (p_tag_we),
        .proc_wtag    (p_wtag),
        .proc_wstate  (p_wstate),
        .snoop_index  (s_index),
        .snoop_we     (s_we),
        .snoop_wstate (s_wstate),
        .proc_tag     (p_tag),
        .proc_state   (p_state),
        .snoop_tag    (s_tag),
        .snoop_state  (s_state)
    );

    l1_data_store u_data_store (
        .clk         (clk),
        .proc_index  (p_data_index),
        .proc_we     (p_data_we),
        .proc_wdata  (p_wdata),
        .snoop_index (s_index),
        .proc_rdata  (p_rdata),
        .snoop_rdata (s_rdata)
    );

    l1_proc_ctrl u_proc_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_req    (cpu_req),
        .cpu_op     (cpu_op),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_done   (cpu_done),
        .cpu_rdata  (cpu_rdata),
        .bus_req    (bus_req),
        .bus_op     (bus_op),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_ack    (bus_ack),
        .bus_rdata  (bus_rdata),
        .bus_shared (bus_shared),
        .tag_rd     (p_tag),
        .state_rd   (p_state),
        .data_rd    (p_rdata),
        .tag_index  (p_tag_index),
        .tag_we     (p_tag_we),
        .tag_wtag   (p_wtag),
        .state_wr   (p_wstate),
        .data_index (p_data_index),
        .data_we    (p_data_we),
        .data_wdata (p_wdata)
    );

    l1_snoop_ctrl u_snoop_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .snoop_req   (snoop_req),
        .snoop_op    (snoop_op),
        .snoop_addr  (snoop_addr),
        .tag_rd      (s_tag),
        .state_rd    (s_state),
        .data_rd     (s_rdata),
        .snoop_resp  (snoop_resp),
        .snoop_hit   (snoop_hit),
        .snoop_dirty (snoop_dirty),
        .snoop_data  (snoop_data),
        .snoop_index (s_index),
        .state_we    (s_we),
        .state_wr    (s_wstate)
    );

endmodule

/* design/l1_defines.svh */
`ifndef L1_DEFINES_SVH
`define L1_DEFINES_SVH

// ============================================================
// level-1 data cache geometry
// ============================================================

// byte address seen by processor, snoop and bus
`define L1_ADDR_WID 16

// one word per line
`define L1_DATA_WID 32

// byte offset inside a word, always zero toward level 2
`define L1_OFFSET_WID 2

// direct mapped line index
`define L1_INDEX_WID 6
`define L1_LINES 64

// remaining upper address bits
`define L1_TAG_WID 8

`endif

/* design/l1_pkg.sv */
`include "l1_defines.svh"

package l1_pkg;

    // line coherence state
    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } mesi_e;

    typedef enum logic {
        CPU_READ,
        CPU_WRITE
    } cpu_op_e;

    // requests toward level 2
    typedef enum logic [1:0] {
        BUS_RD,
        BUS_RDX,
        BUS_UPGR,
        BUS_WB
    } bus_op_e;

    typedef enum logic {
        SNOOP_RD,
        SNOOP_INV
    } snoop_op_e;

endpackage

/* design/l1_proc_ctrl.sv */
`timescale 1ns/10ps
`include "l1_defines.svh"

module l1_proc_ctrl import l1_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     cpu_req,
    input  cpu_op_e                  cpu_op,
    input  logic [`L1_ADDR_WID-1:0]  cpu_addr,
    input  logic [`L1_DATA_WID-1:0]  cpu_wdata,
    output logic                     cpu_done,
    output logic [`L1_DATA_WID-1:0]  cpu_rdata,
    output logic                     bus_req,
    output bus_op_e                  bus_op,
    output logic [`L1_ADDR_WID-1:0]  bus_addr,
    output logic [`L1_DATA_WID-1:0]  bus_wdata,
    input  logic                     bus_ack,
    input  logic [`L1_DATA_WID-1:0]  bus_rdata,
    input  logic                     bus_shared,
    input  logic [`L1_TAG_WID-1:0]   tag_rd,
    input  mesi_e                    state_rd,
    input  logic [`L1_DATA_WID-1:0]  data_rd,
    output logic [`L1_INDEX_WID-1:0] tag_index,
    output logic                     tag_we,
    output logic [`L1_TAG_WID-1:0]   tag_wtag,
    output mesi_e                    state_wr,
    output logic [`L1_INDEX_WID-1:0] data_index,
    output logic                     data_we,
    output logic [`L1_DATA_WID-1:0]  data_wdata
);

    localparam int IDX_LO = `L1_OFFSET_WID;
    localparam int TAG_LO = `L1_OFFSET_WID + `L1_INDEX_WID;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_WAIT,
        ST_FILL_WAIT,
        ST_UPG_WAIT
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // latched request
    cpu_op_e                  req_op;
    logic [`L1_TAG_WID-1:0]   req_tag;
    logic [`L1_INDEX_WID-1:0] req_index;
    logic [`L1_DATA_WID-1:0]  req_wdata;

    logic                     hit;
    logic                     is_write;
    bus_op_e                  fill_op;
    logic                     issue;
    bus_op_e                  issue_op;
    logic [`L1_ADDR_WID-1:0]  issue_addr;
    logic                     done_d;
    logic [`L1_DATA_WID-1:0]  rdata_d;

    assign hit      = (state_rd != MESI_I) && (tag_rd == req_tag);
    assign is_write = (req_op == CPU_WRITE);
    assign fill_op  = is_write ? BUS_RDX : BUS_RD;

    // data read is registered, so present the index one cycle early
    assign data_index = (state_q == ST_IDLE) ? cpu_addr[TAG_LO-1:IDX_LO] : req_index;
    assign tag_index  = req_index;
    assign tag_wtag   = req_tag;

    // ============================================================
    // next state, bus issue and array writes
    // ============================================================
    always_comb begin
        state_d    = state_q;
        issue      = 1'b0;
        issue_op   = fill_op;
        issue_addr = {req_tag, req_index, {`L1_OFFSET_WID{1'b0}}};
        done_d     = 1'b0;
        rdata_d    = data_rd;
        tag_we     = 1'b0;
        state_wr   = state_rd;
        data_we    = 1'b0;
        data_wdata = req_wdata;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit && !is_write) begin
                    done_d  = 1'b1;
                    state_d = ST_IDLE;
                end else if (hit && state_rd != MESI_S) begin
                    // silent E/M -> M
                    tag_we   = 1'b1;
                    state_wr = MESI_M;
                    data_we  = 1'b1;
                    done_d   = 1'b1;
                    state_d  = ST_IDLE;
                end else if (hit) begin
                    issue    = 1'b1;
                    issue_op = BUS_UPGR;
                    state_d  = ST_UPG_WAIT;
                end else if (state_rd == MESI_M) begin
                    // dirty victim goes out under its own tag
                    issue      = 1'b1;
                    issue_op   = BUS_WB;
                    issue_addr = {tag_rd, req_index, {`L1_OFFSET_WID{1'b0}}};
                    state_d    = ST_WB_WAIT;
                end else begin
                    issue   = 1'b1;
                    state_d = ST_FILL_WAIT;
                end
            end
            ST_WB_WAIT: begin
                if (bus_ack) begin
                    tag_we   = 1'b1;
                    state_wr = MESI_I;
                    issue    = 1'b1;
                    state_d  = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                if (bus_ack) begin
                    tag_we  = 1'b1;
                    data_we = 1'b1;
                    if (is_write) begin
                        state_wr = MESI_M;
                    end else begin
                        state_wr   = bus_shared ? MESI_S : MESI_E;
                        data_wdata = bus_rdata;
                    end
                    rdata_d = bus_rdata;
                    done_d  = 1'b1;
                    state_d = ST_IDLE;
                end
            end
            ST_UPG_WAIT: begin
                if (bus_ack) begin
                    tag_we   = 1'b1;
                    state_wr = MESI_M;
                    data_we  = 1'b1;
                    done_d   = 1'b1;
                    state_d  = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            cpu_done <= 1'b0;
            bus_req  <= 1'b0;
        end else begin
            state_q  <= state_d;
            cpu_done <= done_d;
            bus_req  <= issue;
        end
    end

    // request latch and outgoing payloads
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && cpu_req) begin
            req_op    <= cpu_op;
            req_tag   <= cpu_addr[`L1_ADDR_WID-1:TAG_LO];
            req_index <= cpu_addr[TAG_LO-1:IDX_LO];
            req_wdata <= cpu_wdata;
        end
        if (done_d) begin
            cpu_rdata <= rdata_d;
        end
        if (issue) begin
            bus_op    <= issue_op;
            bus_addr  <= issue_addr;
            bus_wdata <= data_rd;
        end
    end

endmodule

/* design/l1_snoop_ctrl.sv */
`timescale 1ns/10ps
`include "l1_defines.svh"

module l1_snoop_ctrl import l1_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     snoop_req,
    input  snoop_op_e                snoop_op,
    input  logic [`L1_ADDR_WID-1:0]  snoop_addr,
    input  logic [`L1_TAG_WID-1:0]   tag_rd,
    input  mesi_e                    state_rd,
    input  logic [`L1_DATA_WID-1:0]  data_rd,
    output logic                     snoop_resp,
    output logic                     snoop_hit,
    output logic                     snoop_dirty,
    output logic [`L1_DATA_WID-1:0]  snoop_data,
    output logic [`L1_INDEX_WID-1:0] snoop_index,
    output logic                     state_we,
    output mesi_e                    state_wr
);

    localparam int IDX_LO = `L1_OFFSET_WID;
    localparam int TAG_LO = `L1_OFFSET_WID + `L1_INDEX_WID;

    logic lookup_hit;

    assign snoop_index = snoop_addr[TAG_LO-1:IDX_LO];
    assign lookup_hit  = (state_rd != MESI_I) &&
                         (tag_rd == snoop_addr[`L1_ADDR_WID-1:TAG_LO]);

    // demote or invalidate in the request cycle
    assign state_we = snoop_req && lookup_hit;
    assign state_wr = (snoop_op == SNOOP_RD) ? MESI_S : MESI_I;

    // data store read is already one cycle behind
    assign snoop_data = data_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snoop_resp  <= 1'b0;
            snoop_hit   <= 1'b0;
            snoop_dirty <= 1'b0;
        end else begin
            snoop_resp  <= snoop_req;
            snoop_hit   <= snoop_req && lookup_hit;
            snoop_dirty <= snoop_req && lookup_hit && (state_rd == MESI_M);
        end
    end

endmodule

/* design/l1_tag_store.sv */
`timescale 1ns/10ps
`include "l1_defines.svh"

module l1_tag_store import l1_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`L1_INDEX_WID-1:0] proc_index,
    input  logic                     proc_we,
    input  logic [`L1_TAG_WID-1:0]   proc_wtag,
    input  mesi_e                    proc_wstate,
    input  logic [`L1_INDEX_WID-1:0] snoop_index,
    input  logic                     snoop_we,
    input  mesi_e                    snoop_wstate,
    output logic [`L1_TAG_WID-1:0]   proc_tag,
    output mesi_e                    proc_state,
    output logic [`L1_TAG_WID-1:0]   snoop_tag,
    output mesi_e                    snoop_state
);

    logic [`L1_TAG_WID-1:0] tag_mem [`L1_LINES];
    mesi_e                  state_mem [`L1_LINES];

    // combinational lookups
    assign proc_tag    = tag_mem[proc_index];
    assign proc_state  = state_mem[proc_index];
    assign snoop_tag   = tag_mem[snoop_index];
    assign snoop_state = state_mem[snoop_index];

    // ============================================================
    // state array
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `L1_LINES; i++) begin
                state_mem[i] <= MESI_I;
            end
        end else begin
            if (proc_we) begin
                state_mem[proc_index] <= proc_wstate;
            end
            // later assignment, so snoop wins on the same index
            if (snoop_we) begin
                state_mem[snoop_index] <= snoop_wstate;
            end
        end
    end

    // tags only change on processor installs
    always_ff @(posedge clk) begin
        if (proc_we) begin
            tag_mem[proc_index] <= proc_wtag;
        end
    end

endmodule

/* flist.f */
+incdir+design
design/l1_pkg.sv
design/l1_tag_store.sv
design/l1_data_store.sv
design/l1_proc_ctrl.sv
design/l1_snoop_ctrl.sv
design/l1_dcache_top.sv
tests/tb_l1_dcache.sv

/* tests/tb_l1_dcache.sv */
`timescale 1ns/10ps
`include "l1_defines.svh"

module tb_l1_dcache import l1_pkg::*;;

    localparam int WORD_WID   = `L1_ADDR_WID - `L1_OFFSET_WID;
    localparam int L2_WORDS   = 1 << WORD_WID;
    localparam int DRIVE_DLY  = 2;
    localparam int DONE_LIMIT = 60;

    // A and C share index 13, B and the miss probe share index 16
    localparam logic [`L1_ADDR_WID-1:0] ADDR_A = 16'h1236;
    localparam logic [`L1_ADDR_WID-1:0] ADDR_B = 16'h2140;
    localparam logic [`L1_ADDR_WID-1:0] ADDR_C = 16'h5634;
    localparam logic [`L1_ADDR_WID-1:0] ADDR_D = 16'h7700;
    localparam logic [`L1_ADDR_WID-1:0] ADDR_E = 16'h9940;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    cpu_req;
    cpu_op_e                 cpu_op;
    logic [`L1_ADDR_WID-1:0] cpu_addr;
    logic [`L1_DATA_WID-1:0] cpu_wdata;
    logic                    cpu_done;
    logic [`L1_DATA_WID-1:0] cpu_rdata;
    logic                    bus_req;
    bus_op_e                 bus_op;
    logic [`L1_ADDR_WID-1:0] bus_addr;
    logic [`L1_DATA_WID-1:0] bus_wdata;
    logic                    bus_ack = 1'b0;
    logic [`L1_DATA_WID-1:0] bus_rdata = '0;
    logic                    bus_shared;
    logic                    snoop_req;
    snoop_op_e               snoop_op;
    logic [`L1_ADDR_WID-1:0] snoop_addr;
    logic                    snoop_resp;
    logic                    snoop_hit;
    logic                    snoop_dirty;
    logic [`L1_DATA_WID-1:0] snoop_data;

    logic [`L1_DATA_WID-1:0] l2_mem [L2_WORDS];
    bus_op_e                 bus_op_q [$];
    logic [`L1_ADDR_WID-1:0] bus_addr_q [$];
    logic [`L1_DATA_WID-1:0] bus_wdata_q [$];
    logic [31:0]             lcg_state = 32'd48815;
    int                      checks = 0;
    int                      errors = 0;

    always #20 clk = ~clk;

    l1_dcache_top u_dut (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [`L1_ADDR_WID-1:0] word_addr(input logic [`L1_ADDR_WID-1:0] a);
        return {a[`L1_ADDR_WID-1:`L1_OFFSET_WID], {`L1_OFFSET_WID{1'b0}}};
    endfunction

    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_bus(input int pos, input bus_op_e op,
                              input logic [`L1_ADDR_WID-1:0] addr);
        checks++;
        assert (bus_op_q.size() > pos) else begin
            $display("bus request %0d never arrived, checked at %0t", pos, $time);
            errors++;
        end
        if (bus_op_q.size() > pos) begin
            check_value("bus_op", 32'(bus_op_q[pos]), 32'(op));
            check_value("bus_addr", 32'(bus_addr_q[pos]), 32'(addr));
        end
    endtask

    task automatic clear_bus_log();
        bus_op_q.delete();
        bus_addr_q.delete();
        bus_wdata_q.delete();
    endtask

    // one request, then wait for cpu_done; cycles counts from the request
    task automatic cpu_access(input cpu_op_e op, input logic [`L1_ADDR_WID-1:0] addr,
                              input logic [`L1_DATA_WID-1:0] wdata,
                              output logic [`L1_DATA_WID-1:0] rdata, output int cycles);
        cpu_req   = 1'b1;
        cpu_op    = op;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        tick();
        cpu_req = 1'b0;
        cycles  = 1;
        while (!cpu_done && cycles < DONE_LIMIT) begin
            tick();
            cycles++;
        end
        checks++;
        assert (cpu_done) else begin
            $display("no cpu_done within %0d cycles, gave up at %0t", DONE_LIMIT, $time);
            errors++;
        end
        rdata = cpu_rdata;
    endtask

    // response timing is fixed at one cycle
    task automatic snoop_access(input snoop_op_e op, input logic [`L1_ADDR_WID-1:0] addr,
                                input logic exp_hit, input logic exp_dirty,
                                input logic [`L1_DATA_WID-1:0] exp_data);
        snoop_req  = 1'b1;
        snoop_op   = op;
        snoop_addr = addr;
        tick();
        snoop_req = 1'b0;
        check_value("snoop_resp", 32'(snoop_resp), 32'd1);
        check_value("snoop_hit", 32'(snoop_hit), 32'(exp_hit));
        check_value("snoop_dirty", 32'(snoop_dirty), 32'(exp_dirty));
        if (exp_dirty) begin
            check_value("snoop_data", snoop_data, exp_data);
        end
    endtask

    task automatic test_report(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
        end
    endtask

    // ============================================================
    // level-2 memory model
    // ============================================================
    always begin : l2_model
        int                  delay;
        logic [WORD_WID-1:0] word;
        tick();
        bus_ack = 1'b0;
        if (arst_n && bus_req) begin
            bus_op_q.push_back(bus_op);
            bus_addr_q.push_back(bus_addr);
            bus_wdata_q.push_back(bus_wdata);
            word = bus_addr[`L1_ADDR_WID-1:`L1_OFFSET_WID];
            if (bus_op == BUS_WB) begin
                l2_mem[word] = bus_wdata;
            end
            delay = 1 + int'((lcg_next() >> 16) % 32'd4);
            repeat (delay) begin
                tick();
            end
            bus_rdata = l2_mem[word];
            bus_ack   = 1'b1;
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        logic [`L1_DATA_WID-1:0] rdata;
        logic [`L1_DATA_WID-1:0] exp;
        int                      cycles;
        int                      err0;
        cpu_req    = 1'b0;
        cpu_op     = CPU_READ;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        bus_shared = 1'b0;
        snoop_req  = 1'b0;
        snoop_op   = SNOOP_RD;
        snoop_addr = '0;
        for (int i = 0; i < L2_WORDS; i++) begin
            l2_mem[i] = lcg_next() ^ (32'(i) * 32'h0001_0003);
        end
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        check_value("cpu_done", 32'(cpu_done), 32'd0);
        check_value("bus_req", 32'(bus_req), 32'd0);
        check_value("snoop_resp", 32'(snoop_resp), 32'd0);
        tick();

        err0 = errors;
        clear_bus_log();
        exp = l2_mem[ADDR_A[`L1_ADDR_WID-1:`L1_OFFSET_WID]];
        cpu_access(CPU_READ, ADDR_A, '0, rdata, cycles);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd1);
        expect_bus(0, BUS_RD, word_addr(ADDR_A));
        check_value("cpu_rdata", rdata, exp);
        clear_bus_log();
        cpu_access(CPU_READ, ADDR_A, '0, rdata, cycles);
        check_value("read hit latency", 32'(cycles), 32'd2);
        check_value("cpu_rdata", rdata, exp);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd0);
        test_report(1, "read miss then read hit", err0);

        err0 = errors;
        clear_bus_log();
        cpu_access(CPU_WRITE, ADDR_A, 32'hcafe_0001, rdata, cycles);
        check_value("write hit latency", 32'(cycles), 32'd2);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd0);
        snoop_access(SNOOP_RD, word_addr(ADDR_A), 1'b1, 1'b1, 32'hcafe_0001);
        cpu_access(CPU_WRITE, ADDR_A, 32'hcafe_0002, rdata, cycles);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd1);
        expect_bus(0, BUS_UPGR, word_addr(ADDR_A));
        test_report(2, "silent write, snoop read, upgrade", err0);

        // shared fill
        err0 = errors;
        clear_bus_log();
        bus_shared = 1'b1;
        exp = l2_mem[ADDR_B[`L1_ADDR_WID-1:`L1_OFFSET_WID]];
        cpu_access(CPU_READ, ADDR_B, '0, rdata, cycles);
        check_value("cpu_rdata", rdata, exp);
        expect_bus(0, BUS_RD, ADDR_B);
        clear_bus_log();
        cpu_access(CPU_WRITE, ADDR_B, 32'hbeef_0003, rdata, cycles);
        bus_shared = 1'b0;
        check_value("bus request count", 32'(bus_op_q.size()), 32'd1);
        expect_bus(0, BUS_UPGR, ADDR_B);
        test_report(3, "shared fill then write", err0);

        err0 = errors;
        clear_bus_log();
        cpu_access(CPU_WRITE, ADDR_C, 32'hface_0004, rdata, cycles);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd2);
        expect_bus(0, BUS_WB, word_addr(ADDR_A));
        if (bus_wdata_q.size() > 0) begin
            check_value("bus_wdata", bus_wdata_q[0], 32'hcafe_0002);
        end
        expect_bus(1, BUS_RDX, ADDR_C);
        clear_bus_log();
        cpu_access(CPU_READ, ADDR_C, '0, rdata, cycles);
        check_value("cpu_rdata", rdata, 32'hface_0004);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd0);
        test_report(4, "dirty victim write-back", err0);

        err0 = errors;
        clear_bus_log();
        snoop_access(SNOOP_INV, ADDR_C, 1'b1, 1'b1, 32'hface_0004);
        exp = l2_mem[ADDR_C[`L1_ADDR_WID-1:`L1_OFFSET_WID]];
        cpu_access(CPU_READ, ADDR_C, '0, rdata, cycles);
        check_value("bus request count", 32'(bus_op_q.size()), 32'd1);
        expect_bus(0, BUS_RD, ADDR_C);
        check_value("cpu_rdata", rdata, exp);
        test_report(5, "snoop invalidate of dirty line", err0);

        // uncached, and a tag mismatch on a live index
        err0 = errors;
        snoop_access(SNOOP_RD, ADDR_D, 1'b0, 1'b0, '0);
        snoop_access(SNOOP_INV, ADDR_E, 1'b0, 1'b0, '0);
        snoop_access(SNOOP_RD, ADDR_B, 1'b1, 1'b1, 32'hbeef_0003);
        test_report(6, "snoop miss", err0);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
